/* hdl/p2r_pkg.sv */
`default_nettype none

package p2r_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int P2R_D            = 13;
    localparam int P2R_LANES        = 4;
    localparam int P2R_NUM_READS    = 16;
    localparam int P2R_NUM_SK_WORDS = 13;
    localparam int P2R_BUF_BITS     = 128;

    // ============================================================
    // data types
    // ============================================================
    typedef logic [23:0]  coef_t;
    typedef logic [95:0]  rd_word_t;
    typedef logic [9:0]   r1_t;
    typedef logic [12:0]  r0_enc_t;
    // lane 0 sits in the low bits of both packed words
    typedef logic [39:0]  pk_word_t;
    typedef logic [51:0]  enc_group_t;
    typedef logic [63:0]  sk_word_t;
    typedef logic [7:0]   addr_t;
    typedef logic [3:0]   rd_idx_t;

    // read controller
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/p2r_rd_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module p2r_rd_ctrl (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           enable,
    input  p2r_pkg::addr_t src_base_addr,
    input  logic           run_done,
    output logic           mem_rd_en,
    output p2r_pkg::addr_t mem_rd_addr
);
    import p2r_pkg::*;

    ctrl_state_t state;
    rd_idx_t     rd_cnt;

    // ============================================================
    // read sequencing
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= IDLE;
            rd_cnt <= '0;
        end else if (zeroize) begin
            state  <= IDLE;
            rd_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // enable only counts here, so runs never overlap
                    if (enable) begin
                        state  <= READ;
                        rd_cnt <= '0;
                    end
                end
                READ: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == rd_idx_t'(P2R_NUM_READS - 1)) begin
                        state <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    // hold until the writer has flushed the last sk word
                    if (run_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // one read per cycle while in READ
    assign mem_rd_en   = (state == READ);
    assign mem_rd_addr = src_base_addr + addr_t'(rd_cnt);

endmodule

`default_nettype wire

/* hdl/p2r_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module p2r_datapath (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  p2r_pkg::rd_word_t   mem_rd_data,
    input  logic                mem_rd_valid,
    output p2r_pkg::pk_word_t   pk_wrdata,
    output p2r_pkg::enc_group_t enc_group,
    output logic                res_valid
);
    import p2r_pkg::*;

    rd_word_t   in_q;
    logic       in_valid;
    pk_word_t   r1_lanes;
    enc_group_t enc_lanes;
    pk_word_t   r1_q;
    enc_group_t enc_q;

    // ============================================================
    // stage 1: input register
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_q     <= '0;
            in_valid <= 1'b0;
        end else if (zeroize) begin
            in_q     <= '0;
            in_valid <= 1'b0;
        end else begin
            in_valid <= mem_rd_valid;
            if (mem_rd_valid) begin
                in_q <= mem_rd_data;
            end
        end
    end

    // per-lane decompose and encode
    for (genvar i = 0; i < P2R_LANES; i++) begin : gen_lane
        coef_t       coef;
        logic [22:0] r;
        logic [23:0] r_sum;
        logic [10:0] r1_full;
        logic [23:0] r0_full;

        assign coef = in_q[i*$bits(coef_t) +: $bits(coef_t)];
        // top bit is outside the value range
        assign r       = coef[22:0];
        assign r_sum   = {1'b0, r} + 24'((1 << (P2R_D - 1)) - 1);
        assign r1_full = r_sum[23:P2R_D];
        assign r0_full = {1'b0, r} - {r1_full, {P2R_D{1'b0}}};

        assign r1_lanes[i*$bits(r1_t) +: $bits(r1_t)] = r1_full[9:0];
        // 4096 - r0, always within 0..8191
        assign enc_lanes[i*$bits(r0_enc_t) +: $bits(r0_enc_t)] =
            r0_enc_t'(1 << (P2R_D - 1)) - r0_full[P2R_D-1:0];
    end

    // ============================================================
    // stage 2: result register
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r1_q      <= '0;
            enc_q     <= '0;
            res_valid <= 1'b0;
        end else if (zeroize) begin
            r1_q      <= '0;
            enc_q     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
            if (in_valid) begin
                r1_q  <= r1_lanes;
                enc_q <= enc_lanes;
            end
        end
    end

    assign pk_wrdata = r1_q;
    assign enc_group = enc_q;

endmodule

`default_nettype wire

/* hdl/p2r_lat_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module p2r_lat_buffer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  p2r_pkg::enc_group_t enc_group,
    input  logic                res_valid,
    output p2r_pkg::sk_word_t   buf_data,
    output logic                buf_valid
);
    import p2r_pkg::*;

    localparam int FILL_W = $clog2(P2R_BUF_BITS) + 1;
    localparam int WR_W   = $bits(enc_group_t);
    localparam int RD_W   = $bits(sk_word_t);

    logic [P2R_BUF_BITS-1:0] store;
    logic [P2R_BUF_BITS-1:0] store_shift;
    logic [P2R_BUF_BITS-1:0] store_next;
    logic [P2R_BUF_BITS-1:0] wr_wide;
    logic [FILL_W-1:0]       fill_cnt;
    logic [FILL_W-1:0]       fill_shift;
    logic [FILL_W-1:0]       fill_next;

    // ============================================================
    // read side
    // ============================================================
    // oldest bits live at the bottom of the store
    assign buf_valid = (fill_cnt >= FILL_W'(RD_W));
    assign buf_data  = store[RD_W-1:0];

    assign wr_wide = {{(P2R_BUF_BITS - WR_W){1'b0}}, enc_group};

    always_comb begin
        // drop the word that leaves this cycle
        if (buf_valid) begin
            store_shift = store >> RD_W;
            fill_shift  = fill_cnt - FILL_W'(RD_W);
        end else begin
            store_shift = store;
            fill_shift  = fill_cnt;
        end

        // append above whatever is still held
        if (res_valid) begin
            store_next = store_shift | (wr_wide << fill_shift);
            fill_next  = fill_shift + FILL_W'(WR_W);
        end else begin
            store_next = store_shift;
            fill_next  = fill_shift;
        end
    end

    // ============================================================
    // store and fill count
    // ============================================================
    // bits above the fill level must stay zero for the OR append,
    // so the store is cleared along with the count
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            store    <= '0;
            fill_cnt <= '0;
        end else if (zeroize) begin
            store    <= '0;
            fill_cnt <= '0;
        end else begin
            store    <= store_next;
            fill_cnt <= fill_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/p2r_sk_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module p2r_sk_writer (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    input  p2r_pkg::addr_t    sk_base_addr,
    input  p2r_pkg::sk_word_t buf_data,
    input  logic              buf_valid,
    input  logic              res_valid,
    output logic              sk_wr_en,
    output p2r_pkg::addr_t    sk_wr_addr,
    output p2r_pkg::sk_word_t sk_wr_data,
    output logic              pk_wren,
    output p2r_pkg::rd_idx_t  pk_wr_addr,
    output logic              run_done,
    output logic              done
);
    import p2r_pkg::*;

    rd_idx_t sk_cnt;
    rd_idx_t pk_idx;
    logic    sk_last;
    logic    done_q;
    logic    last_word;

    assign last_word = (sk_cnt == rd_idx_t'(P2R_NUM_SK_WORDS - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sk_wr_en   <= 1'b0;
            sk_wr_addr <= '0;
            sk_wr_data <= '0;
            sk_cnt     <= '0;
            sk_last    <= 1'b0;
            pk_idx     <= '0;
            done_q     <= 1'b0;
        end else if (zeroize) begin
            sk_wr_en   <= 1'b0;
            sk_wr_addr <= '0;
            sk_wr_data <= '0;
            sk_cnt     <= '0;
            sk_last    <= 1'b0;
            pk_idx     <= '0;
            done_q     <= 1'b0;
        end else begin
            sk_wr_en <= buf_valid;
            // one cycle after the final sk write
            done_q   <= sk_wr_en && sk_last;
            if (buf_valid) begin
                sk_wr_data <= buf_data;
                sk_wr_addr <= sk_base_addr + addr_t'(sk_cnt);
                sk_last    <= last_word;
                sk_cnt     <= last_word ? '0 : sk_cnt + 1'b1;
            end
            // wraps after 16 words, ready for the next run
            if (res_valid) begin
                pk_idx <= pk_idx + 1'b1;
            end
        end
    end

    assign pk_wren    = res_valid;
    assign pk_wr_addr = pk_idx;
    assign run_done   = done_q;
    assign done       = done_q;

endmodule

`default_nettype wire

/* hdl/power2round_top.sv */
`timescale 1ns/1ns
`default_nettype none

module power2round_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize,
    input  logic               enable,
    input  p2r_pkg::addr_t     src_base_addr,
    input  p2r_pkg::addr_t     sk_base_addr,
    input  p2r_pkg::rd_word_t  mem_rd_data,
    input  logic               mem_rd_valid,
    output logic               mem_rd_en,
    output p2r_pkg::addr_t     mem_rd_addr,
    output logic               sk_wr_en,
    output p2r_pkg::addr_t     sk_wr_addr,
    output p2r_pkg::sk_word_t  sk_wr_data,
    output logic               pk_wren,
    output p2r_pkg::rd_idx_t   pk_wr_addr,
    output p2r_pkg::pk_word_t  pk_wrdata,
    output logic               done
);
    import p2r_pkg::*;

    enc_group_t enc_group;
    sk_word_t   buf_data;
    logic       res_valid;
    logic       buf_valid;
    logic       run_done;

    // ============================================================
    // read side
    // ============================================================
    p2r_rd_ctrl p2r_rd_ctrl_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .enable        (enable),
        .src_base_addr (src_base_addr),
        .run_done      (run_done),
        .mem_rd_en     (mem_rd_en),
        .mem_rd_addr   (mem_rd_addr)
    );

    p2r_datapath p2r_datapath_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_valid (mem_rd_valid),
        .pk_wrdata    (pk_wrdata),
        .enc_group    (enc_group),
        .res_valid    (res_valid)
    );

    // ============================================================
    // write side
    // ============================================================
    // 52-bit groups in, 64-bit sk words out
    p2r_lat_buffer p2r_lat_buffer_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .enc_group (enc_group),
        .res_valid (res_valid),
        .buf_data  (buf_data),
        .buf_valid (buf_valid)
    );

    p2r_sk_writer p2r_sk_writer_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .sk_base_addr (sk_base_addr),
        .buf_data     (buf_data),
        .buf_valid    (buf_valid),
        .res_valid    (res_valid),
        .sk_wr_en     (sk_wr_en),
        .sk_wr_addr   (sk_wr_addr),
        .sk_wr_data   (sk_wr_data),
        .pk_wren      (pk_wren),
        .pk_wr_addr   (pk_wr_addr),
        .run_done     (run_done),
        .done         (done)
    );

endmodule

`default_nettype wire

/* verif/power2round_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module power2round_checker (
    input logic       clk,
    input logic       reset_n,
    input logic       zeroize,
    input logic       pk_wren,
    input logic       sk_wr_en,
    input logic       done,
    input logic       buf_valid,
    input logic       res_valid,
    input logic [7:0] fill_cnt
);

    logic [7:0] bits_held;

    // running tally of bits written minus bits read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bits_held <= '0;
        end else if (zeroize) begin
            bits_held <= '0;
        end else begin
            bits_held <= bits_held + (res_valid ? 8'd52 : 8'd0)
                         - (buf_valid ? 8'd64 : 8'd0);
        end
    end

    // ============================================================
    // buffer
    // ============================================================
    a_fill_max: assert property (@(posedge clk) disable iff (!reset_n)
        fill_cnt <= 8'd128)
        else $error("buffer fill count above 128 bits");

    a_buf_level: assert property (@(posedge clk) disable iff (!reset_n)
        buf_valid |-> bits_held >= 8'd64)
        else $error("buffer read with fewer than 64 bits held");

    // ============================================================
    // controls
    // ============================================================
    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    // outputs are registered, so they clear one cycle after zeroize
    a_zeroize_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> !(pk_wren || sk_wr_en || done))
        else $error("write strobe or done while zeroize active");

endmodule

bind power2round_top power2round_checker power2round_checker_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .pk_wren   (pk_wren),
    .sk_wr_en  (sk_wr_en),
    .done      (done),
    .buf_valid (p2r_lat_buffer_inst.buf_valid),
    .res_valid (res_valid),
    .fill_cnt  (p2r_lat_buffer_inst.fill_cnt)
);

`default_nettype wire

/* verif/power2round_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module power2round_tb;
    import p2r_pkg::*;

    localparam int NUM_TDATA = 2 * P2R_NUM_READS + P2R_NUM_SK_WORDS;

    logic     clk;
    logic     reset_n;
    logic     zeroize;
    logic     enable;
    addr_t    src_base_addr;
    addr_t    sk_base_addr;
    rd_word_t mem_rd_data;
    logic     mem_rd_valid;
    logic     mem_rd_en;
    addr_t    mem_rd_addr;
    logic     sk_wr_en;
    addr_t    sk_wr_addr;
    sk_word_t sk_wr_data;
    logic     pk_wren;
    rd_idx_t  pk_wr_addr;
    pk_word_t pk_wrdata;
    logic     done;

    rd_word_t   tdata [0:NUM_TDATA-1];
    rd_word_t   src_mem [0:255];
    pk_word_t   exp_pk [0:P2R_NUM_READS-1];
    sk_word_t   exp_sk [0:P2R_NUM_SK_WORDS-1];
    logic       rd_req;
    addr_t      rd_req_addr;
    logic [1:0] vld_hist;
    logic       checking;
    logic       quiet;
    int         run_id;
    int         mon_run;
    int         rd_seen;
    int         pk_seen;
    int         sk_seen;
    int         done_seen;
    int         cyc;
    int         last_sk_cyc;
    int         value_errs;
    int         proto_errs;
    int         main_errs;
    integer     seed;

    power2round_top power2round_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .enable        (enable),
        .src_base_addr (src_base_addr),
        .sk_base_addr  (sk_base_addr),
        .mem_rd_data   (mem_rd_data),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_en     (mem_rd_en),
        .mem_rd_addr   (mem_rd_addr),
        .sk_wr_en      (sk_wr_en),
        .sk_wr_addr    (sk_wr_addr),
        .sk_wr_data    (sk_wr_data),
        .pk_wren       (pk_wren),
        .pk_wr_addr    (pk_wr_addr),
        .pk_wrdata     (pk_wrdata),
        .done          (done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
        end
    end

    // ============================================================
    // source memory model, one cycle read latency
    // ============================================================
    initial begin
        rd_req      = 1'b0;
        rd_req_addr = '0;
        forever begin
            @(negedge clk);
            rd_req      = mem_rd_en && !zeroize;
            rd_req_addr = mem_rd_addr;
        end
    end

    initial begin
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        forever begin
            @(posedge clk);
            #2;
            mem_rd_valid = rd_req;
            mem_rd_data  = rd_req ? src_mem[rd_req_addr] : '0;
        end
    end

    // ============================================================
    // reference rule and compare tasks
    // ============================================================
    function automatic r1_t high_part(input coef_t c);
        int r;
        r = int'(c[22:0]);
        return r1_t'((r + 4095) >>> 13);
    endfunction

    function automatic r0_enc_t encoded_low_part(input coef_t c);
        int r;
        int hi;
        r  = int'(c[22:0]);
        hi = (r + 4095) >>> 13;
        return r0_enc_t'(4096 - (r - hi * 8192));
    endfunction

    task check_pk(input pk_word_t got, input pk_word_t exp,
                  input rd_idx_t got_idx, input rd_idx_t exp_idx);
        if (got !== exp || got_idx !== exp_idx) begin
            $display("FAIL t=%0t pk write: got %h at %0d, expected %h at %0d",
                     $time, got, got_idx, exp, exp_idx);
            value_errs = value_errs + 1;
        end
    endtask

    task check_sk(input sk_word_t got, input sk_word_t exp,
                  input addr_t got_addr, input addr_t exp_addr);
        if (got !== exp || got_addr !== exp_addr) begin
            $display("FAIL t=%0t sk write: got %h at %h, expected %h at %h",
                     $time, got, got_addr, exp, exp_addr);
            value_errs = value_errs + 1;
        end
    endtask

    task check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t read address: got %h, expected %h", $time, got, exp);
            value_errs = value_errs + 1;
        end
    endtask

    // ============================================================
    // output monitor, sampled on the falling edge
    // ============================================================
    initial begin
        mon_run     = 0;
        rd_seen     = 0;
        pk_seen     = 0;
        sk_seen     = 0;
        done_seen   = 0;
        last_sk_cyc = 0;
        vld_hist    = 2'b00;
        value_errs  = 0;
        proto_errs  = 0;
        forever begin
            @(negedge clk);
            if (run_id != mon_run) begin
                mon_run   = run_id;
                rd_seen   = 0;
                pk_seen   = 0;
                sk_seen   = 0;
                done_seen = 0;
            end
            if (reset_n && checking && !zeroize) begin
                if (mem_rd_en) begin
                    check_addr(mem_rd_addr, src_base_addr + addr_t'(rd_seen));
                    rd_seen = rd_seen + 1;
                end
                // pk write trails the read data by two cycles
                if (pk_wren !== vld_hist[1]) begin
                    $display("pk write strobe out of step with read data at %0t", $time);
                    proto_errs = proto_errs + 1;
                end
                if (pk_wren) begin
                    if (pk_seen < P2R_NUM_READS) begin
                        check_pk(pk_wrdata, exp_pk[pk_seen], pk_wr_addr, rd_idx_t'(pk_seen));
                    end
                    pk_seen = pk_seen + 1;
                end
                if (sk_wr_en) begin
                    if (sk_seen < P2R_NUM_SK_WORDS) begin
                        check_sk(sk_wr_data, exp_sk[sk_seen], sk_wr_addr,
                                 sk_base_addr + addr_t'(sk_seen));
                    end
                    sk_seen     = sk_seen + 1;
                    last_sk_cyc = cyc;
                end
                if (done) begin
                    if (sk_seen != P2R_NUM_SK_WORDS || cyc != last_sk_cyc + 1) begin
                        $display("done pulsed at the wrong time at %0t", $time);
                        proto_errs = proto_errs + 1;
                    end
                    done_seen = done_seen + 1;
                end
            end
            if (reset_n && quiet && (mem_rd_en || pk_wren || sk_wr_en || done)) begin
                $display("unexpected strobe after zeroize at %0t", $time);
                proto_errs = proto_errs + 1;
            end
            if (zeroize) begin
                vld_hist = 2'b00;
            end else begin
                vld_hist = {vld_hist[0], mem_rd_valid};
            end
        end
    end

    // ============================================================
    // run tasks
    // ============================================================
    task automatic load_file_run(input addr_t base);
        for (int j = 0; j < P2R_NUM_READS; j++) begin
            src_mem[base + addr_t'(j)] = tdata[j];
            exp_pk[j] = tdata[P2R_NUM_READS + j][39:0];
        end
        for (int k = 0; k < P2R_NUM_SK_WORDS; k++) begin
            exp_sk[k] = tdata[2 * P2R_NUM_READS + k][63:0];
        end
    endtask

    task automatic load_random_run(input addr_t base);
        logic [831:0] stream;
        rd_word_t     w;
        coef_t        c;
        stream = '0;
        for (int j = 0; j < P2R_NUM_READS; j++) begin
            w = {$random(seed), $random(seed), $random(seed)};
            src_mem[base + addr_t'(j)] = w;
            for (int l = 0; l < P2R_LANES; l++) begin
                c = w[l*24 +: 24];
                exp_pk[j][l*10 +: 10] = high_part(c);
                // lane 0 of word 0 lands in the lowest sk bits
                stream[(j*P2R_LANES + l)*13 +: 13] = encoded_low_part(c);
            end
        end
        for (int k = 0; k < P2R_NUM_SK_WORDS; k++) begin
            exp_sk[k] = stream[k*64 +: 64];
        end
    endtask

    task automatic start_run(input addr_t src, input addr_t sk);
        @(posedge clk);
        #2;
        src_base_addr = src;
        sk_base_addr  = sk;
        run_id        = run_id + 1;
        checking      = 1'b1;
        enable        = 1'b1;
        @(posedge clk);
        #2 enable = 1'b0;
    endtask

    task automatic full_run(input addr_t src, input addr_t sk);
        int n;
        start_run(src, sk);
        // a second enable inside the run must be ignored
        repeat (4) @(posedge clk);
        #2 enable = 1'b1;
        @(posedge clk);
        #2 enable = 1'b0;
        n = 0;
        while (done_seen == 0 && n < 200) begin
            @(posedge clk);
            n = n + 1;
        end
        if (done_seen == 0) begin
            $display("timeout: done did not pulse within 200 cycles at %0t", $time);
            main_errs = main_errs + 1;
        end
        repeat (20) @(posedge clk);
        #2 checking = 1'b0;
        if (rd_seen != 16 || pk_seen != 16 || sk_seen != 13 || done_seen != 1) begin
            $display("run %0d has wrong counts: reads %0d, pk %0d, sk %0d, done %0d",
                     run_id, rd_seen, pk_seen, sk_seen, done_seen);
            main_errs = main_errs + 1;
        end
    endtask

    task automatic zeroize_run(input addr_t src, input addr_t sk);
        int n;
        start_run(src, sk);
        n = 0;
        while (sk_seen < 2 && n < 100) begin
            @(posedge clk);
            n = n + 1;
        end
        if (sk_seen < 2) begin
            $display("timeout: no sk writes before zeroize at %0t", $time);
            main_errs = main_errs + 1;
        end
        #2;
        checking = 1'b0;
        zeroize  = 1'b1;
        @(posedge clk);
        #5;
        if (mem_rd_en || pk_wren || sk_wr_en || done ||
            power2round_top_inst.p2r_lat_buffer_inst.fill_cnt != '0) begin
            $display("zeroize left outputs or buffer fill set at %0t", $time);
            main_errs = main_errs + 1;
        end
        @(posedge clk);
        #2;
        zeroize = 1'b0;
        quiet   = 1'b1;
        repeat (20) @(posedge clk);
        #2 quiet = 1'b0;
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        seed          = 32'h499c;
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        enable        = 1'b0;
        src_base_addr = '0;
        sk_base_addr  = '0;
        checking      = 1'b0;
        quiet         = 1'b0;
        run_id        = 0;
        main_errs     = 0;
        $readmemh("verif/power2round_testdata.txt", tdata);
        for (int a = 0; a < 256; a++) begin
            src_mem[a] = {3{32'hDEAD_0000 | 32'(a)}};
        end

        repeat (16) @(posedge clk);
        #2 reset_n = 1'b1;
        repeat (2) @(posedge clk);

        load_file_run(8'h10);
        full_run(8'h10, 8'h40);
        load_file_run(8'hA0);
        full_run(8'hA0, 8'h05);

        load_file_run(8'h60);
        zeroize_run(8'h60, 8'hC0);

        // fresh runs after zeroize
        load_random_run(8'h30);
        full_run(8'h30, 8'h80);
        load_file_run(8'hF0);
        full_run(8'hF0, 8'hF8);

        $display("errors: value %0d, protocol %0d, sequence %0d",
                 value_errs, proto_errs, main_errs);
        if (value_errs + proto_errs + main_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* power2round_top.f */
hdl/p2r_pkg.sv
hdl/p2r_rd_ctrl.sv
hdl/p2r_datapath.sv
hdl/p2r_lat_buffer.sv
hdl/p2r_sk_writer.sv
hdl/power2round_top.sv
verif/power2round_checker.sv
verif/power2round_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = power2round_tb
FILELIST  = power2round_top.f
OBJ_DIR   = obj_dir

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verif/power2round_testdata.txt */
// lines 0-15: source words {lane3, lane2, lane1, lane0}, 24 bits per coefficient
// lines 16-31: expected pk words, 10-bit r1 per lane; lines 32-44: expected sk words
001FFF_7FE000_001001_001000
009FFF_006000_005001_803000
011FFF_00C000_009001_005000
019FFF_012000_00D001_807000
021FFF_018000_011001_009000
029FFF_01E000_015001_80B000
031FFF_024000_019001_00D000
039FFF_02A000_01D001_80F000
041FFF_030000_021001_011000
049FFF_036000_025001_813000
051FFF_03C000_029001_015000
059FFF_042000_02D001_817000
061FFF_048000_031001_019000
069FFF_04E000_035001_81B000
071FFF_054000_039001_01D000
079FFF_05A000_03D001_81F000
007FF00400
0140300C01
0240601402
0340901C03
0440C02404
0540F02C05
0641203406
0741503C07
0841804408
0941B04C09
0A41E0540A
0B42105C0B
0C4240640C
0D42706C0D
0E42A0740E
0F42D07C0F
000800C003FFE000
FFE000800C003FFE
003FFE000800C003
00C003FFE000800C
00800C003FFE0008
FE000800C003FFE0
03FFE000800C003F
0C003FFE000800C0
0800C003FFE00080
E000800C003FFE00
3FFE000800C003FF
C003FFE000800C00
800C003FFE000800
